/* logic/mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// opcode field, instr[31:26]
`define OP_SPECIAL	6'h00	// register forms, funct selects the op
`define OP_ADDI		6'h08
`define OP_ADDIU	6'h09
`define OP_SLTI		6'h0a
`define OP_SLTIU	6'h0b
`define OP_ANDI		6'h0c
`define OP_ORI		6'h0d
`define OP_XORI		6'h0e
`define OP_LUI		6'h0f

// funct field under OP_SPECIAL, instr[5:0]
`define FUNC_SLL	6'h00
`define FUNC_SRL	6'h02
`define FUNC_SRA	6'h03
`define FUNC_SLLV	6'h04
`define FUNC_SRLV	6'h06
`define FUNC_SRAV	6'h07
`define FUNC_ADD	6'h20
`define FUNC_ADDU	6'h21
`define FUNC_SUB	6'h22
`define FUNC_SUBU	6'h23
`define FUNC_AND	6'h24
`define FUNC_OR		6'h25
`define FUNC_XOR	6'h26
`define FUNC_NOR	6'h27
`define FUNC_SLT	6'h2a
`define FUNC_SLTU	6'h2b

// register field values
`define REG_ZERO	5'd0	// r0, hard wired to zero

// register file depth
`define REG_COUNT	32

`endif

/* logic/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	// alu operation, picked by the decoder
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_slt,
		alu_sltu,
		alu_sll,	// shift by shamt
		alu_srl,
		alu_sra,
		alu_sllv,	// shift by rs[4:0]
		alu_srlv,
		alu_srav,
		alu_lui_pass	// operand b straight through
	} alu_op_t;

	// immediate extension
	typedef enum logic [1:0] {
		ext_zero,
		ext_sign,
		ext_upper	// imm16 in top half, zeros below
	} ext_op_t;

	// exception code reported with exc_valid
	typedef enum logic [1:0] {
		exc_none,
		exc_ri,	// reserved instruction
		exc_ov	// signed overflow
	} exc_t;

endpackage

`default_nettype wire

/* logic/instr_decode.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mips_config.svh"

module instr_decode (
	input wire [31:0] instr,
	output logic [4:0] rs,
	output logic [4:0] rt,
	output logic [4:0] dest,
	output mips_pkg::alu_op_t alu_op,
	output mips_pkg::ext_op_t ext_op,
	output logic imm_sel,
	output logic [15:0] imm16,
	output logic [4:0] shamt,
	output logic ov_en,
	output logic ri
);

	logic [5:0] op;
	logic [5:0] funct;
	logic sp;

	assign op = instr[31:26];
	assign funct = instr[5:0];
	assign sp = (op == `OP_SPECIAL);

	// register forms
	logic op_add, op_addu, op_sub, op_subu;
	logic op_and, op_or, op_xor, op_nor, op_slt, op_sltu;
	logic op_sll, op_srl, op_sra, op_sllv, op_srlv, op_srav;

	assign op_add = sp && (funct == `FUNC_ADD);
	assign op_addu = sp && (funct == `FUNC_ADDU);
	assign op_sub = sp && (funct == `FUNC_SUB);
	assign op_subu = sp && (funct == `FUNC_SUBU);
	assign op_and = sp && (funct == `FUNC_AND);
	assign op_or = sp && (funct == `FUNC_OR);
	assign op_xor = sp && (funct == `FUNC_XOR);
	assign op_nor = sp && (funct == `FUNC_NOR);
	assign op_slt = sp && (funct == `FUNC_SLT);
	assign op_sltu = sp && (funct == `FUNC_SLTU);
	assign op_sll = sp && (funct == `FUNC_SLL);	// nop lands here too
	assign op_srl = sp && (funct == `FUNC_SRL);
	assign op_sra = sp && (funct == `FUNC_SRA);
	assign op_sllv = sp && (funct == `FUNC_SLLV);
	assign op_srlv = sp && (funct == `FUNC_SRLV);
	assign op_srav = sp && (funct == `FUNC_SRAV);

	// immediate forms
	logic op_addi, op_addiu, op_andi, op_ori, op_xori, op_slti, op_sltiu, op_lui;

	assign op_addi = (op == `OP_ADDI);
	assign op_addiu = (op == `OP_ADDIU);
	assign op_andi = (op == `OP_ANDI);
	assign op_ori = (op == `OP_ORI);
	assign op_xori = (op == `OP_XORI);
	assign op_slti = (op == `OP_SLTI);
	assign op_sltiu = (op == `OP_SLTIU);
	assign op_lui = (op == `OP_LUI);

	// instruction classes
	logic calr, cali, shift_imm, shift_var;

	assign calr = op_add | op_addu | op_sub | op_subu | op_and | op_or |
		op_xor | op_nor | op_slt | op_sltu;
	assign shift_imm = op_sll | op_srl | op_sra;
	assign shift_var = op_sllv | op_srlv | op_srav;
	assign cali = op_addi | op_addiu | op_andi | op_ori | op_xori | op_slti | op_sltiu;

	assign ri = !(calr | shift_imm | shift_var | cali | op_lui);
	assign ov_en = op_add | op_addi | op_sub;

	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign dest = (cali | op_lui) ? instr[20:16] : instr[15:11];	// rt for i-type

	assign imm_sel = cali | op_lui;
	assign imm16 = ri ? 16'h0 : instr[15:0];
	assign shamt = ri ? 5'd0 : instr[10:6];

	always_comb begin
		if (op_addi | op_addiu | op_slti | op_sltiu)
			ext_op = mips_pkg::ext_sign;
		else if (op_lui)
			ext_op = mips_pkg::ext_upper;
		else
			ext_op = mips_pkg::ext_zero;	// andi, ori, xori
	end

	always_comb begin
		if (op_sub | op_subu)
			alu_op = mips_pkg::alu_sub;
		else if (op_and | op_andi)
			alu_op = mips_pkg::alu_and;
		else if (op_or | op_ori)
			alu_op = mips_pkg::alu_or;
		else if (op_xor | op_xori)
			alu_op = mips_pkg::alu_xor;
		else if (op_nor)
			alu_op = mips_pkg::alu_nor;
		else if (op_slt | op_slti)
			alu_op = mips_pkg::alu_slt;
		else if (op_sltu | op_sltiu)
			alu_op = mips_pkg::alu_sltu;
		else if (op_sll)
			alu_op = mips_pkg::alu_sll;
		else if (op_srl)
			alu_op = mips_pkg::alu_srl;
		else if (op_sra)
			alu_op = mips_pkg::alu_sra;
		else if (op_sllv)
			alu_op = mips_pkg::alu_sllv;
		else if (op_srlv)
			alu_op = mips_pkg::alu_srlv;
		else if (op_srav)
			alu_op = mips_pkg::alu_srav;
		else if (op_lui)
			alu_op = mips_pkg::alu_lui_pass;
		else
			alu_op = mips_pkg::alu_add;	// add, addu, addi, addiu
	end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mips_config.svh"

module reg_file (
	input wire clk,
	input wire rst,
	input wire [4:0] ra1,
	input wire [4:0] ra2,
	input wire [4:0] wa,
	input wire we,
	input wire [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= 32'h0;
		end else if (we && (wa != `REG_ZERO)) begin
			regs[wa] <= wd;	// r0 writes dropped
		end
	end

	// async read, r0 forced to zero
	assign rd1 = (ra1 == `REG_ZERO) ? 32'h0 : regs[ra1];
	assign rd2 = (ra2 == `REG_ZERO) ? 32'h0 : regs[ra2];

endmodule

`default_nettype wire

/* logic/alu_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_execute (
	input wire clk,
	input wire rst,
	input wire in_valid,
	input wire mips_pkg::alu_op_t alu_op,
	input wire mips_pkg::ext_op_t ext_op,
	input wire imm_sel,
	input wire [15:0] imm16,
	input wire [4:0] shamt,
	input wire [31:0] rs_data,
	input wire [31:0] rt_data,
	input wire [4:0] dest,
	input wire ov_en,
	input wire ri,
	output logic ex_valid,
	output logic [31:0] ex_result,
	output logic [4:0] ex_dest,
	output logic ex_ovf,
	output logic ex_ri
);

	logic [31:0] ext_imm;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] sum;
	logic [31:0] diff;
	logic [31:0] result;
	logic ovf;

	always_comb begin
		case (ext_op)
			mips_pkg::ext_sign: ext_imm = {{16{imm16[15]}}, imm16};
			mips_pkg::ext_upper: ext_imm = {imm16, 16'h0};
			default: ext_imm = {16'h0, imm16};
		endcase
	end

	assign op_a = rs_data;
	assign op_b = imm_sel ? ext_imm : rt_data;
	assign sum = op_a + op_b;
	assign diff = op_a - op_b;

	// shifts always act on rt, which is op_b here since imm_sel is low
	always_comb begin
		case (alu_op)
			mips_pkg::alu_add: result = sum;
			mips_pkg::alu_sub: result = diff;
			mips_pkg::alu_and: result = op_a & op_b;
			mips_pkg::alu_or: result = op_a | op_b;
			mips_pkg::alu_xor: result = op_a ^ op_b;
			mips_pkg::alu_nor: result = ~(op_a | op_b);
			mips_pkg::alu_slt: result = {31'h0, $signed(op_a) < $signed(op_b)};
			mips_pkg::alu_sltu: result = {31'h0, op_a < op_b};
			mips_pkg::alu_sll: result = op_b << shamt;
			mips_pkg::alu_srl: result = op_b >> shamt;
			mips_pkg::alu_sra: result = $signed(op_b) >>> shamt;
			mips_pkg::alu_sllv: result = op_b << op_a[4:0];
			mips_pkg::alu_srlv: result = op_b >> op_a[4:0];
			mips_pkg::alu_srav: result = $signed(op_b) >>> op_a[4:0];
			mips_pkg::alu_lui_pass: result = op_b;
			default: result = sum;
		endcase
	end

	// signed overflow, only for add, addi and sub
	always_comb begin
		ovf = 1'b0;
		if (ov_en) begin
			if (alu_op == mips_pkg::alu_add)
				ovf = (op_a[31] == op_b[31]) && (sum[31] != op_a[31]);
			else if (alu_op == mips_pkg::alu_sub)
				ovf = (op_a[31] != op_b[31]) && (diff[31] != op_a[31]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			ex_valid <= 1'b0;
		else
			ex_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			ex_result <= result;
			ex_dest <= dest;
			ex_ovf <= ovf;
			ex_ri <= ri;
		end
	end

endmodule

`default_nettype wire

/* logic/result_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module result_stage (
	input wire clk,
	input wire rst,
	input wire ex_valid,
	input wire [31:0] ex_result,
	input wire [4:0] ex_dest,
	input wire ex_ovf,
	input wire ex_ri,
	output logic wb_valid,
	output logic [4:0] wb_addr,
	output logic [31:0] wb_data,
	output logic exc_valid,
	output mips_pkg::exc_t exc_code
);

	logic fault;

	assign fault = ex_ri | ex_ovf;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			exc_valid <= 1'b0;
		end else begin
			wb_valid <= ex_valid && !fault;
			exc_valid <= ex_valid && fault;
		end
	end

	// payload only moves on its own pulse
	always_ff @(posedge clk) begin
		if (ex_valid && !fault) begin
			wb_addr <= ex_dest;
			wb_data <= ex_result;
		end
		if (ex_valid && fault)
			exc_code <= ex_ri ? mips_pkg::exc_ri : mips_pkg::exc_ov;	// ri wins
	end

endmodule

`default_nettype wire

/* logic/mips_core_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mips_config.svh"

module mips_core_top (
	input wire clk,
	input wire rst,
	input wire instr_valid,
	input wire [31:0] instr,
	output logic wb_valid,
	output logic [$clog2(`REG_COUNT)-1:0] wb_addr,
	output logic [31:0] wb_data,
	output logic exc_valid,
	output mips_pkg::exc_t exc_code
);

	// decode outputs
	logic [$clog2(`REG_COUNT)-1:0] rs;
	logic [$clog2(`REG_COUNT)-1:0] rt;
	logic [$clog2(`REG_COUNT)-1:0] dest;
	mips_pkg::alu_op_t alu_op;
	mips_pkg::ext_op_t ext_op;
	logic imm_sel;
	logic [15:0] imm16;
	logic [4:0] shamt;
	logic ov_en;
	logic ri;

	// register read data
	logic [31:0] rs_data;
	logic [31:0] rt_data;

	// execute stage
	logic ex_valid;
	logic [31:0] ex_result;
	logic [$clog2(`REG_COUNT)-1:0] ex_dest;
	logic ex_ovf;
	logic ex_ri;

	instr_decode u_decode (
		.instr(instr),
		.rs(rs),
		.rt(rt),
		.dest(dest),
		.alu_op(alu_op),
		.ext_op(ext_op),
		.imm_sel(imm_sel),
		.imm16(imm16),
		.shamt(shamt),
		.ov_en(ov_en),
		.ri(ri)
	);

	// write port fed back from the result stage
	reg_file u_regs (
		.clk(clk),
		.rst(rst),
		.ra1(rs),
		.ra2(rt),
		.wa(wb_addr),
		.we(wb_valid),
		.wd(wb_data),
		.rd1(rs_data),
		.rd2(rt_data)
	);

	alu_execute u_execute (
		.clk(clk),
		.rst(rst),
		.in_valid(instr_valid),
		.alu_op(alu_op),
		.ext_op(ext_op),
		.imm_sel(imm_sel),
		.imm16(imm16),
		.shamt(shamt),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.dest(dest),
		.ov_en(ov_en),
		.ri(ri),
		.ex_valid(ex_valid),
		.ex_result(ex_result),
		.ex_dest(ex_dest),
		.ex_ovf(ex_ovf),
		.ex_ri(ex_ri)
	);

	result_stage u_result (
		.clk(clk),
		.rst(rst),
		.ex_valid(ex_valid),
		.ex_result(ex_result),
		.ex_dest(ex_dest),
		.ex_ovf(ex_ovf),
		.ex_ri(ex_ri),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.exc_valid(exc_valid),
		.exc_code(exc_code)
	);

endmodule

`default_nettype wire

/* sim/mips_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mips_config.svh"

module mips_core_tb;

	localparam bit KIND_WB = 1'b0;
	localparam bit KIND_EXC = 1'b1;

	logic clk;
	logic rst;
	logic instr_valid;
	logic [31:0] instr;
	logic wb_valid;
	logic [4:0] wb_addr;
	logic [31:0] wb_data;
	logic exc_valid;
	mips_pkg::exc_t exc_code;

	// stimulus table, one slot per test
	string t_name [$];
	logic [31:0] t_instr [$];
	bit t_kind [$];
	logic [4:0] t_addr [$];
	logic [31:0] t_data [$];
	mips_pkg::exc_t t_code [$];

	int pass_count;
	int fail_count;
	bit table_ready;
	bit reset_ok;

	mips_core_top DUT (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.instr(instr),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.exc_valid(exc_valid),
		.exc_code(exc_code)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {`OP_SPECIAL, rs, rt, rd, sh, funct};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic add_wb(input string name, input logic [31:0] word, input logic [4:0] addr,
			input logic [31:0] data);
		t_name.push_back(name);
		t_instr.push_back(word);
		t_kind.push_back(KIND_WB);
		t_addr.push_back(addr);
		t_data.push_back(data);
		t_code.push_back(mips_pkg::exc_none);
	endtask

	task automatic add_exc(input string name, input logic [31:0] word, input mips_pkg::exc_t code);
		t_name.push_back(name);
		t_instr.push_back(word);
		t_kind.push_back(KIND_EXC);
		t_addr.push_back(5'd0);
		t_data.push_back(32'h0);
		t_code.push_back(code);
	endtask

	// earlier entries set up registers for later ones
	task automatic build_table();
		add_wb("addu_unwritten", enc_r(`FUNC_ADDU, 0, 5, 1, 0), 1, 32'h0);	// r5 still zero
		add_wb("lui_r2", enc_i(`OP_LUI, 0, 2, 16'h1234), 2, 32'h12340000);
		add_wb("ori_r2", enc_i(`OP_ORI, 2, 2, 16'h5678), 2, 32'h12345678);
		add_wb("lui_r3", enc_i(`OP_LUI, 0, 3, 16'hffff), 3, 32'hffff0000);
		add_wb("ori_r3", enc_i(`OP_ORI, 3, 3, 16'h8000), 3, 32'hffff8000);
		add_wb("addiu_sign", enc_i(`OP_ADDIU, 0, 4, 16'hfffc), 4, 32'hfffffffc);
		add_wb("slti_sign", enc_i(`OP_SLTI, 4, 5, 16'hffff), 5, 32'h1);	// -4 < -1
		add_wb("slti_neg_imm", enc_i(`OP_SLTI, 0, 28, 16'hffff), 28, 32'h0);	// 0 < -1 false
		add_wb("andi_zero", enc_i(`OP_ANDI, 3, 6, 16'hffff), 6, 32'h00008000);
		add_wb("xori_zero", enc_i(`OP_XORI, 2, 7, 16'hffff), 7, 32'h1234a987);
		// 0xffff8000 below 0xffffffff only when the immediate is sign extended
		add_wb("sltiu_sign", enc_i(`OP_SLTIU, 3, 8, 16'hffff), 8, 32'h1);
		// register forms on r2 and r3
		add_wb("add", enc_r(`FUNC_ADD, 2, 4, 9, 0), 9, 32'h12345674);
		add_wb("subu", enc_r(`FUNC_SUBU, 2, 3, 10, 0), 10, 32'h1234d678);
		add_wb("and", enc_r(`FUNC_AND, 2, 3, 11, 0), 11, 32'h12340000);
		add_wb("or", enc_r(`FUNC_OR, 2, 3, 12, 0), 12, 32'hffffd678);
		add_wb("xor", enc_r(`FUNC_XOR, 2, 3, 13, 0), 13, 32'hedcbd678);
		add_wb("nor", enc_r(`FUNC_NOR, 2, 3, 14, 0), 14, 32'h00002987);
		add_wb("slt", enc_r(`FUNC_SLT, 3, 2, 15, 0), 15, 32'h1);
		add_wb("sltu", enc_r(`FUNC_SLTU, 3, 2, 16, 0), 16, 32'h0);
		// shifts, variable amounts from r5 = 1 and r4 low bits = 28
		add_wb("sll", enc_r(`FUNC_SLL, 0, 2, 17, 4), 17, 32'h23456780);
		add_wb("srl", enc_r(`FUNC_SRL, 0, 3, 18, 8), 18, 32'h00ffff80);
		add_wb("sra", enc_r(`FUNC_SRA, 0, 3, 19, 8), 19, 32'hffffff80);
		add_wb("sllv", enc_r(`FUNC_SLLV, 5, 2, 20, 0), 20, 32'h2468acf0);
		add_wb("srlv", enc_r(`FUNC_SRLV, 4, 3, 21, 0), 21, 32'h0000000f);
		add_wb("srav", enc_r(`FUNC_SRAV, 4, 3, 22, 0), 22, 32'hffffffff);
		// overflow
		add_wb("lui_r23", enc_i(`OP_LUI, 0, 23, 16'h7fff), 23, 32'h7fff0000);
		add_wb("ori_r23", enc_i(`OP_ORI, 23, 23, 16'hffff), 23, 32'h7fffffff);
		add_wb("addiu_r24", enc_i(`OP_ADDIU, 0, 24, 16'h0055), 24, 32'h00000055);
		add_exc("add_ovf", enc_r(`FUNC_ADD, 23, 5, 24, 0), mips_pkg::exc_ov);
		add_exc("addi_ovf", enc_i(`OP_ADDI, 23, 24, 16'h0001), mips_pkg::exc_ov);
		add_wb("r24_kept", enc_r(`FUNC_ADDU, 24, 0, 25, 0), 25, 32'h00000055);
		add_wb("addu_wrap", enc_r(`FUNC_ADDU, 23, 5, 26, 0), 26, 32'h80000000);
		// reserved encoding and r0
		add_exc("reserved", {6'h3f, 26'h0}, mips_pkg::exc_ri);
		add_wb("write_r0", enc_i(`OP_ADDIU, 0, 0, 16'h1234), 0, 32'h00001234);
		add_wb("read_r0", enc_r(`FUNC_ADDU, 0, 0, 27, 0), 27, 32'h0);
		add_wb("nop", 32'h0, 0, 32'h0);	// sll r0, r0, 0
	endtask

	task automatic check_pulse(input int i);
		bit ok;
		ok = 1'b1;
		if (t_kind[i] == KIND_WB) begin
			if (wb_valid !== 1'b1 || exc_valid !== 1'b0) begin
				$display("FAILED %s: no write-back pulse two cycles after the strobe", t_name[i]);
				ok = 1'b0;
			end else if (wb_addr !== t_addr[i] || wb_data !== t_data[i]) begin
				$display("FAILED %s: expected r%0d = %h, actual r%0d = %h",
					t_name[i], t_addr[i], t_data[i], wb_addr, wb_data);
				ok = 1'b0;
			end
		end else begin
			if (exc_valid !== 1'b1 || wb_valid !== 1'b0) begin
				$display("FAILED %s: no exception pulse two cycles after the strobe", t_name[i]);
				ok = 1'b0;
			end else if (exc_code !== t_code[i]) begin
				$display("FAILED %s: expected exc_code %s, actual exc_code %s",
					t_name[i], t_code[i].name(), exc_code.name());
				ok = 1'b0;
			end
		end
		if (ok) begin
			$display("PASSED %s", t_name[i]);
			pass_count++;
		end else begin
			fail_count++;
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		instr_valid = 1'b1;	// held through reset, which must swallow it
		instr = 32'h0;
		pass_count = 0;
		fail_count = 0;
		reset_ok = 1'b1;
		build_table();
		table_ready = 1'b1;

		// 16 rising edges with rst high, outputs must stay idle
		repeat (15) begin
			@(posedge clk);
			@(negedge clk);
			if (wb_valid !== 1'b0 || exc_valid !== 1'b0)
				reset_ok = 1'b0;
		end
		@(posedge clk);
		rst <= 1'b0;
		instr_valid <= 1'b0;
		repeat (2) begin
			@(negedge clk);
			if (wb_valid !== 1'b0 || exc_valid !== 1'b0)
				reset_ok = 1'b0;
		end
		if (reset_ok) begin
			$display("PASSED reset_idle");
			pass_count++;
		end else begin
			$display("FAILED reset_idle: a valid output was high during or right after reset");
			fail_count++;
		end

		@(posedge clk);
		for (int i = 0; i < t_name.size(); i++) begin
			instr <= t_instr[i];
			instr_valid <= 1'b1;
			@(posedge clk);
			instr_valid <= 1'b0;
			@(posedge clk);
			@(negedge clk);	// pulse lives between edges N+2 and N+3
			check_pulse(i);
			@(posedge clk);
		end

		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// watchdog sized from the table length
	initial begin
		int limit_ns;
		wait (table_ready);
		limit_ns = (16 + 3 * t_name.size() + 20) * 10;
		#(limit_ns);
		$display("timeout: the test table did not finish in time");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+logic
logic/mips_pkg.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/alu_execute.sv
logic/result_stage.sv
logic/mips_core_top.sv
sim/mips_core_tb.sv

/* run.sh */
#!/bin/bash
# build and run the core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -f all.f --top-module mips_core_tb -o mips_core_sim \
	&& ./obj_dir/mips_core_sim | tee /dev/stderr | grep -qx "NO ERRORS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
